/* Makefile */
# Verilator build and run of the operand stage testbench

SIM     = verilator
FLAGS   = --binary --timing --assert -j 0
TOP     = op_stage_tb
FLIST   = all.f
OBJ_DIR = obj_dir
BIN     = $(OBJ_DIR)/V$(TOP)
LOG     = sim.log
SRCS    = $(wildcard *.sv) $(wildcard *.svh)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Pass or fail comes from the log, not the exit status
run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* all.f */
+incdir+.
opstage_pkg.sv
reg_file.sv
fwd_ctrl.sv
operand_muxes.sv
op_stage_top.sv
op_stage_sva.sv
op_stage_tb.sv

/* fwd_ctrl.sv */
////////////////////
// Forwarding control
// Instruction decode, immediate sign extension, operand source select
////////////////////

`timescale 1ns/1ps

`include "opstage_settings.svh"

module fwd_ctrl import opstage_pkg::*; (
	input  insn_word_t id_insn,
	input  fwd_src_t   ex_res,
	input  fwd_src_t   wb_res,
	output reg_addr_t  ra_addr,
	output reg_addr_t  rb_addr,
	output op_sel_t    sel_a,
	output op_sel_t    sel_b,
	output operand_t   simm
);

	// Opcode bit 5 marks the immediate form
	logic is_imm;

	// Source for one register operand
	// Execute wins over write-back
	// Register 0 never forwarded
	function automatic op_sel_t pick_src(reg_addr_t src, fwd_src_t ex, fwd_src_t wb);
		op_sel_t sel;
		sel = sel_rf;
		if (src != '0) begin
			if (ex.valid && ex.rd == src) begin
				sel = sel_ex;
			end else if (wb.valid && wb.rd == src) begin
				sel = sel_wb;
			end
		end
		return sel;
	endfunction

	assign is_imm = id_insn.r_form.opcode[5];

	////////////////////
	// Decode
	////////////////////

	// ra sits in the same bits in both forms
	assign ra_addr = id_insn.r_form.ra;
	// No second register in i_form so register 0 is read
	assign rb_addr = is_imm ? '0 : id_insn.r_form.rb;

	// Sign extend the 16-bit immediate
	assign simm = {{(`OPSTAGE_WIDTH-16){id_insn.i_form.imm[15]}}, id_insn.i_form.imm};

	////////////////////
	// Source select
	////////////////////

	assign sel_a = pick_src(ra_addr, ex_res, wb_res);
	assign sel_b = is_imm ? sel_imm : pick_src(rb_addr, ex_res, wb_res);

endmodule

/* op_stage_sva.sv */
////////////////////
// Operand register assertions
// Freeze hold, save flag entry, reset value
////////////////////

`timescale 1ns/1ps

module op_stage_sva import opstage_pkg::*; (
	input logic       clk,
	input logic       rst_n,
	input logic       id_freeze,
	input logic       ex_freeze,
	input logic [1:0] saved,
	input operand_t   operand_a,
	input operand_t   operand_b
);

	// Execute freeze holds both operand registers
	hold_on_ex_freeze: assert property (
		@(posedge clk) disable iff (!rst_n)
		ex_freeze |=> ($stable(operand_a) && $stable(operand_b))
	) else $error("operands changed while ex_freeze was high");

	// A save flag is only set by a decode freeze
	save_needs_id_freeze: assert property (
		@(posedge clk) disable iff (!rst_n)
		($rose(saved[0]) || $rose(saved[1])) |-> $past(id_freeze)
	) else $error("save flag set without id_freeze");

	// Reset clears both operands
	zero_after_reset: assert property (
		@(posedge clk)
		!rst_n |=> (operand_a == '0 && operand_b == '0)
	) else $error("operands not zero after reset");

endmodule

// Attached to every operand register block
bind operand_muxes op_stage_sva u_op_stage_sva (
	.clk       (clk),
	.rst_n     (rst_n),
	.id_freeze (id_freeze),
	.ex_freeze (ex_freeze),
	.saved     (saved),
	.operand_a (operand_a),
	.operand_b (operand_b)
);

/* op_stage_tb.sv */
////////////////////
// Operand stage testbench
// Directed tests against a reference register model
////////////////////

`timescale 1ns/1ps

`include "opstage_settings.svh"

module op_stage_tb import opstage_pkg::*; ();

	localparam int RESET_CYCLES  = 4;
	localparam int RESET_TIMEOUT = 50;

	logic       clk;
	logic       rst_n;
	insn_word_t id_insn;
	logic       id_freeze;
	logic       ex_freeze;
	fwd_src_t   ex_res;
	fwd_src_t   wb_res;
	operand_t   operand_a;
	operand_t   operand_b;

	// Reference copy of the register file
	operand_t model [`OPSTAGE_REGS];
	integer   seed;
	int       checks;
	int       errors;

	op_stage_top DUT (
		.clk       (clk),
		.rst_n     (rst_n),
		.id_insn   (id_insn),
		.id_freeze (id_freeze),
		.ex_freeze (ex_freeze),
		.ex_res    (ex_res),
		.wb_res    (wb_res),
		.operand_a (operand_a),
		.operand_b (operand_b)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	////////////////////
	// Helpers
	////////////////////

	function automatic insn_word_t make_r(reg_addr_t ra, reg_addr_t rb);
		insn_word_t w;
		w = '0;
		w.r_form.opcode = 6'h01;
		w.r_form.rd = 5'd1;
		w.r_form.ra = ra;
		w.r_form.rb = rb;
		return w;
	endfunction

	// Opcode bit 5 set selects the immediate form
	function automatic insn_word_t make_i(reg_addr_t ra, logic [15:0] imm);
		insn_word_t w;
		w = '0;
		w.i_form.opcode = 6'h21;
		w.i_form.rd = 5'd1;
		w.i_form.ra = ra;
		w.i_form.imm = imm;
		return w;
	endfunction

	// Register 0 is zero, then execute, then write-back, then the register itself
	function automatic operand_t expect_src(reg_addr_t r, fwd_src_t ex, fwd_src_t wb);
		if (r == '0)
			return '0;
		if (ex.valid && ex.rd == r)
			return ex.data;
		if (wb.valid && wb.rd == r)
			return wb.data;
		return model[r];
	endfunction

	function automatic operand_t sext16(logic [15:0] imm);
		return imm[15] ? (32'hffff_0000 | imm) : {16'h0000, imm};
	endfunction

	// Write rule of the register file
	function automatic void write_model(fwd_src_t wb);
		if (wb.valid && wb.rd != '0)
			model[wb.rd] = wb.data;
	endfunction

	task automatic check_operand(string name, operand_t exp, operand_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("mismatch %s: expected %08h, actual %08h", name, exp, act);
		end
	endtask

	task automatic check_pair(operand_t exp_a, operand_t exp_b);
		check_operand("operand_a", exp_a, operand_a);
		check_operand("operand_b", exp_b, operand_b);
	endtask

	task automatic drive(insn_word_t insn, fwd_src_t ex, fwd_src_t wb, logic idf, logic exf);
		@(posedge clk);
		id_insn   <= insn;
		ex_res    <= ex;
		wb_res    <= wb;
		id_freeze <= idf;
		ex_freeze <= exf;
	endtask

	// Loading edge, then sample at the falling edge
	task automatic settle();
		@(posedge clk);
		@(negedge clk);
	endtask

	// One unfrozen r_form instruction checked one cycle later
	task automatic run_r(reg_addr_t ra, reg_addr_t rb, fwd_src_t ex, fwd_src_t wb);
		operand_t exp_a;
		operand_t exp_b;
		exp_a = expect_src(ra, ex, wb);
		exp_b = expect_src(rb, ex, wb);
		drive(make_r(ra, rb), ex, wb, 1'b0, 1'b0);
		write_model(wb);
		settle();
		check_pair(exp_a, exp_b);
	endtask

	task automatic wait_reset(output bit seen);
		int n;
		seen = 1'b0;
		n = 0;
		while (!seen && n < RESET_TIMEOUT) begin
			@(posedge clk);
			seen = (rst_n === 1'b1);
			n++;
		end
	endtask

	////////////////////
	// Tests
	////////////////////

	// Sampled after the last reset edge, before any load
	task automatic reset_values();
		int e0;
		e0 = errors;
		@(negedge clk);
		check_pair('0, '0);
		$display("reset: %0d errors", errors - e0);
	endtask

	task automatic register_reads();
		int e0;
		int r;
		fwd_src_t wb;
		e0 = errors;
		// Fill every register through the write-back bus
		for (r = 1; r < `OPSTAGE_REGS; r++) begin
			wb = {1'b1, reg_addr_t'(r), operand_t'($random(seed))};
			drive(make_r('0, '0), '0, wb, 1'b0, 1'b0);
			write_model(wb);
		end
		run_r(5'd0, 5'd3, '0, '0);
		for (r = 0; r < 8; r++)
			run_r(reg_addr_t'($random(seed)), reg_addr_t'($random(seed)), '0, '0);
		$display("register reads: %0d errors", errors - e0);
	endtask

	task automatic immediate_operand();
		int e0;
		int i;
		reg_addr_t ra;
		operand_t exp_a;
		logic [15:0] imms [5];
		e0 = errors;
		imms = '{16'h1234, 16'h8001, 16'h7fff, 16'hffff, 16'h0000};
		for (i = 0; i < 5; i++) begin
			ra = reg_addr_t'(i * 7 + 2);
			exp_a = expect_src(ra, '0, '0);
			drive(make_i(ra, imms[i]), '0, '0, 1'b0, 1'b0);
			settle();
			check_pair(exp_a, sext16(imms[i]));
		end
		$display("immediate: %0d errors", errors - e0);
	endtask

	task automatic forwarding_paths();
		int e0;
		operand_t d1;
		operand_t d2;
		e0 = errors;
		d1 = $random(seed);
		d2 = $random(seed);
		run_r(5'd5, 5'd9, {1'b1, 5'd5, d1}, '0);
		// Write-back to the same register in the load cycle
		run_r(5'd5, 5'd9, '0, {1'b1, 5'd9, d2});
		run_r(5'd5, 5'd9, '0, '0);
		// Execute wins over write-back
		run_r(5'd5, 5'd9, {1'b1, 5'd5, d2}, {1'b1, 5'd5, d1});
		run_r(5'd0, 5'd0, {1'b1, 5'd0, d1}, {1'b1, 5'd0, d2});
		run_r(5'd5, 5'd0, '0, '0);
		$display("forwarding: %0d errors", errors - e0);
	endtask

	task automatic ex_freeze_hold();
		int e0;
		e0 = errors;
		run_r(5'd3, 5'd4, '0, '0);
		drive(make_r(5'd6, 5'd7), '0, '0, 1'b0, 1'b1);
		settle();
		check_pair(model[3], model[4]);
		drive(make_r(5'd8, 5'd10), '0, '0, 1'b0, 1'b1);
		settle();
		check_pair(model[3], model[4]);
		// New values one cycle after release
		drive(make_r(5'd8, 5'd10), '0, '0, 1'b0, 1'b0);
		settle();
		check_pair(model[8], model[10]);
		$display("ex_freeze: %0d errors", errors - e0);
	endtask

	task automatic id_freeze_once();
		int e0;
		e0 = errors;
		run_r(5'd11, 5'd12, '0, '0);
		// Loads once under id_freeze
		drive(make_r(5'd13, 5'd14), '0, '0, 1'b1, 1'b0);
		settle();
		check_pair(model[13], model[14]);
		drive(make_r(5'd15, 5'd16), '0, '0, 1'b1, 1'b0);
		settle();
		check_pair(model[13], model[14]);
		// First free cycle clears the flag and loads nothing
		drive(make_r(5'd15, 5'd16), '0, '0, 1'b0, 1'b0);
		settle();
		check_pair(model[13], model[14]);
		settle();
		check_pair(model[15], model[16]);
		$display("id_freeze: %0d errors", errors - e0);
	endtask

	initial begin
		bit seen;
		seed = 32'h4cb8;
		checks = 0;
		errors = 0;
		foreach (model[i])
			model[i] = '0;
		// Nonzero forwarded data on both operands during reset
		rst_n     <= 1'b0;
		id_insn   <= make_r(5'd5, 5'd5);
		id_freeze <= 1'b0;
		ex_freeze <= 1'b0;
		ex_res    <= {1'b1, 5'd5, 32'h5a5a_c3c3};
		wb_res    <= '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n   <= 1'b1;
		id_insn <= '0;
		ex_res  <= '0;
		reset_values();
		wait_reset(seen);
		if (!seen) begin
			$display("reset release not seen within %0d cycles", RESET_TIMEOUT);
			$display("test failed");
			$finish;
		end else begin
			register_reads();
			immediate_operand();
			forwarding_paths();
			ex_freeze_hold();
			id_freeze_once();
			$display("checks: %0d, errors: %0d", checks, errors);
			if (errors == 0) begin
				$display("test passed");
			end else begin
				$display("test failed");
			end
			$finish;
		end
	end

endmodule

/* op_stage_top.sv */
////////////////////
// Operand stage top level
// Register file, forwarding control and operand registers
////////////////////

`timescale 1ns/1ps

module op_stage_top import opstage_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  insn_word_t id_insn,
	input  logic       id_freeze,
	input  logic       ex_freeze,
	input  fwd_src_t   ex_res,
	input  fwd_src_t   wb_res,
	output operand_t   operand_a,
	output operand_t   operand_b
);

	// Register read addresses from decode
	reg_addr_t ra_addr;
	reg_addr_t rb_addr;

	// Register read data
	operand_t rf_data_a;
	operand_t rf_data_b;

	// Source selects and immediate
	op_sel_t  sel_a;
	op_sel_t  sel_b;
	operand_t simm;

	////////////////////
	// Instances
	////////////////////

	fwd_ctrl u_fwd_ctrl (
		.id_insn (id_insn),
		.ex_res  (ex_res),
		.wb_res  (wb_res),
		.ra_addr (ra_addr),
		.rb_addr (rb_addr),
		.sel_a   (sel_a),
		.sel_b   (sel_b),
		.simm    (simm)
	);

	// Written straight from the write-back bus
	reg_file u_reg_file (
		.clk       (clk),
		.rst_n     (rst_n),
		.ra_addr   (ra_addr),
		.rb_addr   (rb_addr),
		.wb_res    (wb_res),
		.rf_data_a (rf_data_a),
		.rf_data_b (rf_data_b)
	);

	// Forwarded data taken from the result buses
	operand_muxes u_operand_muxes (
		.clk       (clk),
		.rst_n     (rst_n),
		.id_freeze (id_freeze),
		.ex_freeze (ex_freeze),
		.rf_data_a (rf_data_a),
		.rf_data_b (rf_data_b),
		.ex_forw   (ex_res.data),
		.wb_forw   (wb_res.data),
		.simm      (simm),
		.sel_a     (sel_a),
		.sel_b     (sel_b),
		.operand_a (operand_a),
		.operand_b (operand_b)
	);

endmodule

/* operand_muxes.sv */
////////////////////
// Operand multiplexers and operand registers
// Freeze handling with one save flag per operand
////////////////////

`timescale 1ns/1ps

module operand_muxes import opstage_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     id_freeze,
	input  logic     ex_freeze,
	input  operand_t rf_data_a,
	input  operand_t rf_data_b,
	input  operand_t ex_forw,
	input  operand_t wb_forw,
	input  operand_t simm,
	input  op_sel_t  sel_a,
	input  op_sel_t  sel_b,
	output operand_t operand_a,
	output operand_t operand_b
);

	// Index 0 is operand A, index 1 is operand B
	operand_t   muxed [2];
	operand_t   op_q [2];
	logic [1:0] saved;

	// One source mux, shared by both operands
	function automatic operand_t mux_src(op_sel_t sel, operand_t rf, operand_t imm,
			operand_t ex, operand_t wb);
		operand_t val;
		case (sel)
			sel_imm: val = imm;
			sel_ex:  val = ex;
			sel_wb:  val = wb;
			default: val = rf;
		endcase
		return val;
	endfunction

	////////////////////
	// Source muxes
	////////////////////

	// sel_a never asks for the immediate
	always_comb begin
		muxed[0] = mux_src(sel_a, rf_data_a, simm, ex_forw, wb_forw);
		muxed[1] = mux_src(sel_b, rf_data_b, simm, ex_forw, wb_forw);
	end

	////////////////////
	// Operand registers
	////////////////////

	always_ff @(posedge clk) begin
		for (int i = 0; i < 2; i++) begin
			if (!rst_n) begin
				op_q[i]  <= '0;
				saved[i] <= 1'b0;
			end else if (!ex_freeze && id_freeze && !saved[i]) begin
				// First cycle of a decode freeze, capture once
				op_q[i]  <= muxed[i];
				saved[i] <= 1'b1;
			end else if (!ex_freeze && !saved[i]) begin
				// Normal flow
				op_q[i] <= muxed[i];
			end else if (!ex_freeze && !id_freeze) begin
				// Freeze gone, drop the flag and skip this load
				saved[i] <= 1'b0;
			end
			// ex_freeze holds everything
		end
	end

	assign operand_a = op_q[0];
	assign operand_b = op_q[1];

endmodule

/* opstage_pkg.sv */
////////////////////
// Operand stage types
// Operand word, register number, source selector,
// instruction word views and in-flight result bus
////////////////////

`include "opstage_settings.svh"

package opstage_pkg;

	typedef logic [`OPSTAGE_WIDTH-1:0] operand_t;
	typedef logic [`OPSTAGE_RADDR_W-1:0] reg_addr_t;

	// Where an operand comes from
	typedef enum logic [`OPSTAGE_SEL_W-1:0] {
		sel_rf  = `OPSTAGE_SEL_RF,
		sel_imm = `OPSTAGE_SEL_IMM,
		sel_ex  = `OPSTAGE_SEL_EX,
		sel_wb  = `OPSTAGE_SEL_WB
	} op_sel_t;

	////////////////////
	// Instruction word
	////////////////////

	// Register-register form, low 11 bits unused
	typedef struct packed {
		logic [5:0]  opcode;
		reg_addr_t   rd;
		reg_addr_t   ra;
		reg_addr_t   rb;
		logic [10:0] unused;
	} r_form_t;

	// Register-immediate form
	typedef struct packed {
		logic [5:0]  opcode;
		reg_addr_t   rd;
		reg_addr_t   ra;
		logic [15:0] imm;
	} i_form_t;

	// Opcode bit 5 picks the i_form view
	typedef union packed {
		r_form_t r_form;
		i_form_t i_form;
	} insn_word_t;

	// Result in flight from execute or write-back
	typedef struct packed {
		logic      valid;
		reg_addr_t rd;
		operand_t  data;
	} fwd_src_t;

endpackage

/* opstage_settings.svh */
////////////////////
// Operand stage build settings
// Data width, register file size and operand selector codes
////////////////////

`ifndef OPSTAGE_SETTINGS_SVH
`define OPSTAGE_SETTINGS_SVH

// Operand and register word width
`define OPSTAGE_WIDTH 32

// Register file geometry
`define OPSTAGE_REGS 32
`define OPSTAGE_RADDR_W 5

// Operand source selector
`define OPSTAGE_SEL_W 2
`define OPSTAGE_SEL_RF 2'd0
`define OPSTAGE_SEL_IMM 2'd1
`define OPSTAGE_SEL_EX 2'd2
`define OPSTAGE_SEL_WB 2'd3

`endif

/* reg_file.sv */
////////////////////
// Register file
// Two combinational read ports, one write port fed by write-back
////////////////////

`timescale 1ns/1ps

`include "opstage_settings.svh"

module reg_file import opstage_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  reg_addr_t ra_addr,
	input  reg_addr_t rb_addr,
	input  fwd_src_t  wb_res,
	output operand_t  rf_data_a,
	output operand_t  rf_data_b
);

	// Register array, entry 0 never written
	operand_t regs [`OPSTAGE_REGS];

	// Write-back only for a valid result to a real register
	logic wr_en;

	assign wr_en = wb_res.valid && (wb_res.rd != '0);

	////////////////////
	// Write port
	////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			// Whole array starts at zero
			for (int i = 0; i < `OPSTAGE_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wb_res.rd] <= wb_res.data;
		end
	end

	////////////////////
	// Read ports
	////////////////////

	// Old value on a same-cycle write, forwarding covers the new one
	// Register 0 is hard zero
	assign rf_data_a = (ra_addr == '0) ? '0 : regs[ra_addr];
	assign rf_data_b = (rb_addr == '0) ? '0 : regs[rb_addr];

endmodule
